//--- build.sh
#!/bin/sh
# Build and run the emesh_cdc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/sim_emesh_cdc

verilator --binary --timing --assert --top-module tb_emesh_cdc \
  -f emesh_cdc.f -o sim_emesh_cdc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$SIM" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- emesh_cdc.f
+incdir+include
rtl/emesh_pkg.sv
rtl/memory_dp.sv
rtl/synchronizer.sv
rtl/fifo_full_block.sv
rtl/fifo_empty_block.sv
rtl/fifo_async.sv
rtl/packet_router.sv
rtl/packet_arbiter.sv
rtl/emesh_cdc_top.sv
tb/tb_emesh_cdc.sv

//--- include/emesh_cdc_macros.svh
`ifndef EMESH_CDC_MACROS_SVH
`define EMESH_CDC_MACROS_SVH

// ########################################
// Mesh packet and channel sizing
// ########################################

// Full mesh packet, write bit down to spare bit
`define EMESH_PW 104

// Words per channel FIFO, power of two only
`define EMESH_DEPTH 16

// Channel 0 for writes, channel 1 for read requests
`define EMESH_NCH 2

// Free slots left when prog_full rises
// Covers pointer sync lag plus the registered in_wait
`define EMESH_PROG_MARGIN 4

`endif

//--- rtl/emesh_cdc_top.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module emesh_cdc_top import emesh_pkg::*; (
  // Write domain
  input  logic          wr_clk,
  input  logic          wr_rst,
  input  logic          in_access,
  input  emesh_packet_t in_packet,
  output logic          in_wait,
  // Read domain
  input  logic          rd_clk,
  input  logic          rd_rst,
  output logic          out_access,
  output emesh_packet_t out_packet,
  input  logic          out_wait
);

  logic [`EMESH_NCH-1:0] ch_wr_en;      // wr domain
  logic [`EMESH_NCH-1:0] ch_prog_full;  // wr domain
  logic [`EMESH_NCH-1:0] ch_rd_en;      // rd domain from here down
  logic [`EMESH_NCH-1:0] ch_empty;
  logic [`EMESH_NCH-1:0] ch_valid;
  emesh_packet_t         ch_dout [`EMESH_NCH];

  packet_router packet_router (
    .wr_clk       (wr_clk),
    .wr_rst       (wr_rst),
    .in_access    (in_access),
    .in_packet    (in_packet),
    .ch_prog_full (ch_prog_full),
    .ch_wr_en     (ch_wr_en),
    .in_wait      (in_wait)
  );

  // ########################################
  // Channel FIFOs
  // ########################################
  for (genvar i = 0; i < `EMESH_NCH; i++) begin : g_ch
    // din is shared, only wr_en picks the channel
    fifo_async fifo_async (
      .wr_clk    (wr_clk),
      .wr_rst    (wr_rst),
      .rd_clk    (rd_clk),
      .rd_rst    (rd_rst),
      .wr_en     (ch_wr_en[i]),
      .din       (in_packet),
      .full      (),             // Margin keeps this low
      .prog_full (ch_prog_full[i]),
      .rd_en     (ch_rd_en[i]),
      .dout      (ch_dout[i]),
      .empty     (ch_empty[i]),
      .valid     (ch_valid[i])
    );
  end

  packet_arbiter packet_arbiter (
    .rd_clk     (rd_clk),
    .rd_rst     (rd_rst),
    .ch_empty   (ch_empty),
    .ch_valid   (ch_valid),
    .ch_dout    (ch_dout),
    .out_wait   (out_wait),
    .ch_rd_en   (ch_rd_en),
    .out_access (out_access),
    .out_packet (out_packet)
  );

endmodule

//--- rtl/emesh_pkg.sv
package emesh_pkg;

  `include "emesh_cdc_macros.svh"

  // Address bits of one channel memory
  localparam int FIFO_AW = $clog2(`EMESH_DEPTH);

  // Mesh packet, msb first
  typedef struct packed {
    logic        write;     // 1 = write transaction, 0 = read request
    logic [1:0]  datamode;  // Transfer size
    logic [3:0]  ctrlmode;
    logic [31:0] dst_addr;
    logic [31:0] data;
    logic [31:0] src_addr;  // Return address for reads
    logic        spare;
  } emesh_packet_t;

  typedef logic [FIFO_AW:0]   fifo_ptr_t;   // Extra wrap bit on top
  typedef logic [FIFO_AW-1:0] fifo_addr_t;

  // Last channel served by the drain arbiter
  typedef enum logic {
    gnt_ch0,
    gnt_ch1
  } grant_t;

  // ########################################
  // Gray code helpers
  // ########################################

  function automatic fifo_ptr_t bin2gray(input fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[FIFO_AW] = gray[FIFO_AW];  // Msb passes straight through
    for (int i = FIFO_AW - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- rtl/fifo_async.sv
`timescale 1ns/1ps

module fifo_async import emesh_pkg::*; (
  input  logic          wr_clk,
  input  logic          wr_rst,
  input  logic          rd_clk,
  input  logic          rd_rst,
  input  logic          wr_en,
  input  emesh_packet_t din,
  output logic          full,
  output logic          prog_full,
  input  logic          rd_en,
  output emesh_packet_t dout,
  output logic          empty,
  output logic          valid
);

  fifo_ptr_t  wr_gray_pointer;     // wr domain, own pointer
  fifo_ptr_t  wr_rd_gray_pointer;  // wr domain, copy of read pointer
  fifo_ptr_t  rd_gray_pointer;     // rd domain, own pointer
  fifo_ptr_t  rd_wr_gray_pointer;  // rd domain, copy of write pointer
  fifo_addr_t wr_addr;
  fifo_addr_t rd_addr;

  // dout is good the cycle after a pop
  always_ff @(posedge rd_clk or posedge rd_rst) begin
    if (rd_rst) begin
      valid <= 1'b0;
    end else begin
      valid <= rd_en;
    end
  end

  memory_dp memory_dp (
    .wr_clk  (wr_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (din),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (dout)
  );

  // Write side
  fifo_full_block fifo_full_block (
    .wr_clk             (wr_clk),
    .reset              (wr_rst),
    .wr_write           (wr_en),
    .wr_rd_gray_pointer (wr_rd_gray_pointer),
    .wr_addr            (wr_addr),
    .wr_gray_pointer    (wr_gray_pointer),
    .wr_fifo_full       (full),
    .wr_fifo_prog_full  (prog_full)
  );

  // Read side
  fifo_empty_block fifo_empty_block (
    .rd_clk             (rd_clk),
    .reset              (rd_rst),
    .rd_read            (rd_en),
    .rd_wr_gray_pointer (rd_wr_gray_pointer),
    .rd_addr            (rd_addr),
    .rd_gray_pointer    (rd_gray_pointer),
    .rd_fifo_empty      (empty)
  );

  // ########################################
  // Pointer crossings
  // ########################################
  synchronizer rd2wr_sync (
    .clk   (wr_clk),
    .reset (wr_rst),
    .in    (rd_gray_pointer),
    .out   (wr_rd_gray_pointer)
  );

  synchronizer wr2rd_sync (
    .clk   (rd_clk),
    .reset (rd_rst),
    .in    (wr_gray_pointer),
    .out   (rd_wr_gray_pointer)
  );

endmodule

//--- rtl/fifo_empty_block.sv
`timescale 1ns/1ps

module fifo_empty_block import emesh_pkg::*; (
  input  logic       rd_clk,
  input  logic       reset,
  input  logic       rd_read,
  input  fifo_ptr_t  rd_wr_gray_pointer,  // Write pointer, already synced
  output fifo_addr_t rd_addr,
  output fifo_ptr_t  rd_gray_pointer,
  output logic       rd_fifo_empty
);

  fifo_ptr_t rd_binary;
  fifo_ptr_t rd_binary_next;
  fifo_ptr_t rd_gray_next;

  // ########################################
  // Read pointer
  // ########################################
  assign rd_binary_next = rd_binary + fifo_ptr_t'(rd_read);
  assign rd_gray_next   = bin2gray(rd_binary_next);
  assign rd_addr        = rd_binary[FIFO_AW-1:0];  // Memory reads current slot

  // Empty looks at the pointer after this read
  // so a pop of the last word flags empty on the very next cycle
  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      rd_binary       <= '0;
      rd_gray_pointer <= '0;
      rd_fifo_empty   <= 1'b1;  // Nothing written yet
    end else begin
      rd_binary       <= rd_binary_next;
      rd_gray_pointer <= rd_gray_next;                          // To wr domain
      rd_fifo_empty   <= (rd_gray_next == rd_wr_gray_pointer);  // Equal incl wrap bit
    end
  end

  // Arbiter has to honour empty
  a_no_read_when_empty : assert property (
    @(posedge rd_clk) disable iff (reset)
    !(rd_read && rd_fifo_empty)
  );

endmodule

//--- rtl/fifo_full_block.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module fifo_full_block import emesh_pkg::*; (
  input  logic       wr_clk,
  input  logic       reset,
  input  logic       wr_write,
  input  fifo_ptr_t  wr_rd_gray_pointer,  // Read pointer, already synced
  output fifo_addr_t wr_addr,
  output fifo_ptr_t  wr_gray_pointer,
  output logic       wr_fifo_full,
  output logic       wr_fifo_prog_full
);

  // Fill levels for the two flags
  localparam fifo_ptr_t FULL_LEVEL = fifo_ptr_t'(`EMESH_DEPTH);
  localparam fifo_ptr_t PROG_LEVEL = fifo_ptr_t'(`EMESH_DEPTH - `EMESH_PROG_MARGIN);

  fifo_ptr_t wr_binary;       // Local write pointer
  fifo_ptr_t wr_binary_next;
  fifo_ptr_t wr_rd_binary;    // Read pointer back in binary
  fifo_ptr_t wr_count_next;   // Words held after this cycle

  // ########################################
  // Pointer and word count
  // ########################################
  assign wr_binary_next = wr_binary + fifo_ptr_t'(wr_write);
  assign wr_rd_binary   = gray2bin(wr_rd_gray_pointer);
  assign wr_count_next  = wr_binary_next - wr_rd_binary;  // Wraps cleanly mod 2*depth
  assign wr_addr        = wr_binary[FIFO_AW-1:0];         // Drop wrap bit

  // Stale read pointer only overstates the count, so flags err on the safe side
  always_ff @(posedge wr_clk or posedge reset) begin
    if (reset) begin
      wr_binary         <= '0;
      wr_gray_pointer   <= '0;
      wr_fifo_full      <= 1'b0;
      wr_fifo_prog_full <= 1'b0;
    end else begin
      wr_binary         <= wr_binary_next;
      wr_gray_pointer   <= bin2gray(wr_binary_next);  // Goes to rd2wr crossing
      wr_fifo_full      <= (wr_count_next == FULL_LEVEL);
      wr_fifo_prog_full <= (wr_count_next >= PROG_LEVEL);
    end
  end

  // Router margin must keep the source off a full channel
  a_no_write_when_full : assert property (
    @(posedge wr_clk) disable iff (reset)
    !(wr_write && wr_fifo_full)
  );

endmodule

//--- rtl/memory_dp.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module memory_dp import emesh_pkg::*; (
  input  logic          wr_clk,
  input  logic          wr_en,
  input  fifo_addr_t    wr_addr,
  input  emesh_packet_t wr_data,
  input  logic          rd_clk,
  input  logic          rd_en,
  input  fifo_addr_t    rd_addr,
  output emesh_packet_t rd_data
);

  // Storage kept as raw words
  logic [`EMESH_PW-1:0] ram [`EMESH_DEPTH];

  // ########################################
  // Write port, wr_clk domain
  // ########################################
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      ram[wr_addr] <= wr_data;  // Whole word every time
    end
  end

  // ########################################
  // Read port, rd_clk domain
  // ########################################
  // Data lands one cycle after rd_en
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= ram[rd_addr];
    end
  end

endmodule

//--- rtl/packet_arbiter.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module packet_arbiter import emesh_pkg::*; (
  input  logic                  rd_clk,
  input  logic                  rd_rst,
  input  logic [`EMESH_NCH-1:0] ch_empty,
  input  logic [`EMESH_NCH-1:0] ch_valid,
  input  emesh_packet_t         ch_dout [`EMESH_NCH],
  input  logic                  out_wait,
  output logic [`EMESH_NCH-1:0] ch_rd_en,
  output logic                  out_access,
  output emesh_packet_t         out_packet
);

  localparam int SW = $clog2(`EMESH_NCH);  // Channel index width

  grant_t        last_gnt;  // Channel served most recently
  logic          pick_any;
  logic [SW-1:0] pick_idx;

  // ########################################
  // Round robin pick
  // ########################################
  // Scan starts one past the last grant
  always_comb begin
    int start_ch;
    int ch;
    pick_any = 1'b0;
    pick_idx = '0;
    start_ch = (int'(last_gnt) + 1) % `EMESH_NCH;
    for (int k = 0; k < `EMESH_NCH; k++) begin
      ch = (start_ch + k) % `EMESH_NCH;
      if (!ch_empty[ch] && !pick_any) begin
        pick_any = 1'b1;
        pick_idx = SW'(ch);
      end
    end
  end

  // No new pop while the sink waits
  always_comb begin
    ch_rd_en = '0;
    if (pick_any && !out_wait) begin
      ch_rd_en[pick_idx] = 1'b1;
    end
  end

  always_ff @(posedge rd_clk or posedge rd_rst) begin
    if (rd_rst) begin
      last_gnt <= gnt_ch1;  // Channel 0 goes first
    end else if (|ch_rd_en) begin
      last_gnt <= grant_t'(pick_idx);
    end
  end

  // ########################################
  // Output mux
  // ########################################
  assign out_access = |ch_valid;  // One pop per cycle, so one valid at most

  always_comb begin
    out_packet = '0;
    for (int i = 0; i < `EMESH_NCH; i++) begin
      if (ch_valid[i]) begin
        out_packet = ch_dout[i];
      end
    end
  end

  a_rd_en_onehot : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    $onehot0(ch_rd_en)
  );

endmodule

//--- rtl/packet_router.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module packet_router import emesh_pkg::*; (
  input  logic                  wr_clk,
  input  logic                  wr_rst,
  input  logic                  in_access,
  input  emesh_packet_t         in_packet,
  input  logic [`EMESH_NCH-1:0] ch_prog_full,
  output logic [`EMESH_NCH-1:0] ch_wr_en,
  output logic                  in_wait
);

  // ########################################
  // Channel select
  // ########################################
  // Same cycle as in_access, no buffering here
  always_comb begin
    ch_wr_en = '0;
    if (in_access) begin
      if (in_packet.write) begin
        ch_wr_en[0] = 1'b1;  // Write transaction
      end else begin
        ch_wr_en[1] = 1'b1;  // Read request
      end
    end
  end

  // Any channel near full stalls the whole source
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      in_wait <= 1'b0;
    end else begin
      in_wait <= |ch_prog_full;
    end
  end

  // in_wait seen here was set on the edge before, source must hold
  a_no_access_in_wait : assert property (
    @(posedge wr_clk) disable iff (wr_rst)
    in_wait |-> !in_access
  );

endmodule

//--- rtl/synchronizer.sv
`timescale 1ns/1ps

module synchronizer import emesh_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  fifo_ptr_t in,
  output fifo_ptr_t out
);

  // First stage may go metastable
  fifo_ptr_t sync_q;

  // Input is Gray coded, so at most one bit is in flight
  // Either the old or the new pointer comes out, never a mix
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_q <= '0;
      out    <= '0;
    end else begin
      sync_q <= in;      // Capture from other domain
      out    <= sync_q;  // Settled copy
    end
  end

endmodule

//--- tb/emesh_patterns.hex
// One 104-bit packet per line: write|datamode|ctrlmode|dst_addr|data|src_addr|spare
// Top bit is the write bit, so a first digit of 8 or above goes to channel 0
80000001000111100000000100
04000002000000000000000200
90000001004222200010000104
88000001008333300020000108
10000002004000000000000204
A200000100C44440003000010C
80000001010555500040000110
2000000200C00000000000020C
81000001014666600050000114
80000001018777700060000118
00000002010000000010000210
C000000101C88880007000011C
80000001020999900080000120
90000001024AAAA00090000124
08000002014000000020000214
F0000001028BBBB000A0000128
8000000102CCCCC000B000012C
80000001030DDDD000C0000130
84000001034EEEE000D0000134
30000002018000000030000218

//--- tb/tb_emesh_cdc.sv
`timescale 1ns/1ps
`include "emesh_cdc_macros.svh"

module tb_emesh_cdc import emesh_pkg::*; ();

  localparam int NPAT        = 20;
  localparam int BURST_CYC   = 60;   // Sink held off this long
  localparam int IDLE_CYC    = 20;
  localparam int TIMEOUT_CYC = NPAT * 12 + 200;
  // prog_full level plus the one write that slips in while in_wait registers
  localparam int MAX_OCC     = `EMESH_DEPTH - `EMESH_PROG_MARGIN + 1;

  logic          wr_clk = 1'b0;
  logic          rd_clk = 1'b0;
  logic          wr_rst;
  logic          rd_rst;
  logic          in_access;
  emesh_packet_t in_packet;
  logic          in_wait;
  logic          out_access;
  emesh_packet_t out_packet;
  logic          out_wait;

  logic [`EMESH_PW-1:0] pat_mem [NPAT];
  emesh_packet_t        exp_wr_q[$];  // Channel 0 expectations
  emesh_packet_t        exp_rd_q[$];  // Channel 1 expectations

  int   seed        = 32'h9d9f;
  int   accepted [2] = '{0, 0};  // Source side, per channel
  int   delivered [2] = '{0, 0};  // Sink side, per channel
  int   out_count   = 0;
  int   cycle_count = 0;
  logic checks_on   = 1'b0;
  logic drive_go    = 1'b0;
  logic drive_done  = 1'b0;
  logic saw_in_wait = 1'b0;

  always #7 wr_clk = ~wr_clk;   // 14 ns
  always #10 rd_clk = ~rd_clk;  // 20 ns

  emesh_cdc_top dut_i (
    .wr_clk     (wr_clk),
    .wr_rst     (wr_rst),
    .in_access  (in_access),
    .in_packet  (in_packet),
    .in_wait    (in_wait),
    .rd_clk     (rd_clk),
    .rd_rst     (rd_rst),
    .out_access (out_access),
    .out_packet (out_packet),
    .out_wait   (out_wait)
  );

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Pops the head of the queue chosen by the write bit and compares
  task automatic check_output(input emesh_packet_t got);
    emesh_packet_t exp;
    int            ch;
    ch = got.write ? 0 : 1;
    if (ch == 0) begin
      assert (exp_wr_q.size() > 0) else begin
        $display("Extra out_access on channel 0 at %0t, no write packet left", $time);
        stop_on_failure();
      end
      exp = exp_wr_q.pop_front();
    end else begin
      assert (exp_rd_q.size() > 0) else begin
        $display("Extra out_access on channel 1 at %0t, no read request left", $time);
        stop_on_failure();
      end
      exp = exp_rd_q.pop_front();
    end
    assert (got == exp) else begin
      $display("ERR t=%0t out_packet: expected %h, got %h", $time, exp, got);
      stop_on_failure();
    end
    delivered[ch]++;
    out_count++;
  endtask

  // ########################################
  // Reset, burst phase, random stall, end
  // ########################################
  initial begin : main_seq
    rd_rst   = 1'b1;
    wr_rst   = 1'b1;
    out_wait = 1'b0;
    repeat (4) @(posedge rd_clk);
    #2;
    rd_rst = 1'b0;
    wr_rst = 1'b0;
    @(posedge rd_clk);
    #2;
    // Quiet outputs before any traffic
    assert (!out_access) else begin
      $display("ERR t=%0t out_access: expected 0, got %b", $time, out_access);
      stop_on_failure();
    end
    assert (!in_wait) else begin
      $display("ERR t=%0t in_wait: expected 0, got %b", $time, in_wait);
      stop_on_failure();
    end
    checks_on = 1'b1;
    out_wait  = 1'b1;  // Sink blocked, FIFOs fill
    drive_go  = 1'b1;
    repeat (BURST_CYC) @(posedge rd_clk);
    #2;
    assert (saw_in_wait) else begin
      $display("in_wait never rose while the sink was held off");
      stop_on_failure();
    end
    // Drain with about one stalled cycle in three
    while (out_count < NPAT) begin
      out_wait = (($unsigned($random(seed)) % 3) == 0);
      @(posedge rd_clk);
      #2;
    end
    out_wait = 1'b0;
    repeat (IDLE_CYC) @(posedge rd_clk);  // Any stray strobe is caught here
    #2;
    assert (drive_done && out_count == NPAT && exp_wr_q.size() == 0 && exp_rd_q.size() == 0)
    begin
      $display("RESULT: PASS");
    end else begin
      $display("Only %0d of %0d packets delivered", out_count, NPAT);
      stop_on_failure();
    end
    $finish;
  end

  // ########################################
  // Source, write domain
  // ########################################
  initial begin : source
    int ch;
    in_access = 1'b0;
    in_packet = '0;
    wait (drive_go);
    @(posedge wr_clk);
    #2;
    for (int i = 0; i < NPAT; i++) begin
      while (in_wait) begin  // Hold while the channels are near full
        in_access = 1'b0;
        @(posedge wr_clk);
        #2;
      end
      in_access = 1'b1;
      in_packet = emesh_packet_t'(pat_mem[i]);
      ch = in_packet.write ? 0 : 1;
      accepted[ch]++;
      assert (accepted[ch] - delivered[ch] <= MAX_OCC) else begin
        $display("ERR t=%0t ch%0d occupancy: expected <= %0d, got %0d", $time, ch,
                 MAX_OCC, accepted[ch] - delivered[ch]);
        stop_on_failure();
      end
      @(posedge wr_clk);
      #2;
    end
    in_access  = 1'b0;
    drive_done = 1'b1;
  end

  always @(negedge wr_clk) begin
    if (in_wait) saw_in_wait = 1'b1;
  end

  // ########################################
  // Sink monitor, sampled mid cycle
  // ########################################
  initial begin : monitor
    logic prev_wait;
    prev_wait = 1'b0;
    $readmemh("tb/emesh_patterns.hex", pat_mem);
    for (int i = 0; i < NPAT; i++) begin
      if (pat_mem[i][`EMESH_PW-1]) exp_wr_q.push_back(emesh_packet_t'(pat_mem[i]));
      else exp_rd_q.push_back(emesh_packet_t'(pat_mem[i]));
    end
    forever begin
      @(negedge rd_clk);
      if (checks_on) begin
        // Whole cycle of out_wait means no pop, so no strobe now
        if (prev_wait) begin
          assert (!out_access) else begin
            $display("ERR t=%0t out_access: expected 0, got %b", $time, out_access);
            stop_on_failure();
          end
        end
        if (out_access) check_output(out_packet);
        prev_wait = out_wait;
      end
    end
  end

  always @(posedge rd_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYC) begin
      $display("Timeout after %0d rd_clk cycles with %0d of %0d packets delivered",
               cycle_count, out_count, NPAT);
      stop_on_failure();
    end
  end

endmodule
